//--- design/overlay_pkg.sv
package overlay_pkg;

    typedef logic [9:0] coord_t;

    // rgb565 layout of a camera or sprite word
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    typedef union packed {
        logic [15:0] raw;
        rgb565_t     field;
    } pixel_u;

    // ball sprite
    localparam int BALL_SIZE = 20;

    // font geometry
    localparam int FONT_W     = 8;
    localparam int FONT_H     = 8;
    localparam int TEXT_SCALE = 2;

    // score box origin
    localparam int SCORE_X = 500;
    localparam int SCORE_Y = 40;

    // end-of-game banner
    localparam int BANNER_Y     = 200;
    localparam int GAMEOVER_X   = 250;
    localparam int LOSE_X       = 280;
    localparam int GAMEOVER_LEN = 9;
    localparam int LOSE_LEN     = 4;

    // character 0 sits at the leftmost slot
    localparam logic [0:8][7:0] GAMEOVER_STR = "GAME OVER";
    localparam logic [0:3][7:0] LOSE_STR     = "LOSE";

    localparam logic [7:0] ASCII_ZERO = 8'h30;

    // colours
    localparam logic [15:0] TEXT_WHITE = 16'hFFFF;
    localparam logic [15:0] BANNER_RED = 16'hF001;
    localparam logic [15:0] BLACK      = 16'h0000;

endpackage

//--- design/beam_if.sv
`timescale 1ns/1ps

interface beam_if;
    import overlay_pkg::*;

    coord_t     x;
    coord_t     y;
    coord_t     ball_x;
    coord_t     ball_y;
    pixel_u     camera;
    pixel_u     sprite;
    logic [7:0] score;
    logic       game_over;
    logic       player_two;
    logic       ball_send_trigger;
    logic       is_idle;

    modport source (
        output x, y, ball_x, ball_y, camera, sprite, score,
        output game_over, player_two, ball_send_trigger, is_idle
    );

    modport consumer (
        input x, y, ball_x, ball_y, camera, sprite, score,
        input game_over, player_two, ball_send_trigger, is_idle
    );

endinterface

//--- design/glyph_rom.sv
`timescale 1ns/1ps

module glyph_rom (
    input  logic [7:0] code,
    input  logic [2:0] row,
    output logic [7:0] bits
);

    // row 0 first, leftmost column in bit 7
    logic [0:7][7:0] glyph;

    always_comb begin
        case (code)
            8'h30: glyph = {8'b00111100, 8'b01100110, 8'b01101110, 8'b01110110,
                            8'b01100110, 8'b01100110, 8'b00111100, 8'b00000000};
            8'h31: glyph = {8'b00011000, 8'b00111000, 8'b00011000, 8'b00011000,
                            8'b00011000, 8'b00011000, 8'b01111110, 8'b00000000};
            8'h32: glyph = {8'b00111100, 8'b01100110, 8'b00000110, 8'b00001100,
                            8'b00110000, 8'b01100000, 8'b01111110, 8'b00000000};
            8'h33: glyph = {8'b00111100, 8'b01100110, 8'b00000110, 8'b00011100,
                            8'b00000110, 8'b01100110, 8'b00111100, 8'b00000000};
            8'h34: glyph = {8'b00001100, 8'b00011100, 8'b00111100, 8'b01101100,
                            8'b01111110, 8'b00001100, 8'b00001100, 8'b00000000};
            8'h35: glyph = {8'b01111110, 8'b01100000, 8'b01111100, 8'b00000110,
                            8'b00000110, 8'b01100110, 8'b00111100, 8'b00000000};
            8'h36: glyph = {8'b00111100, 8'b01100000, 8'b01111100, 8'b01100110,
                            8'b01100110, 8'b01100110, 8'b00111100, 8'b00000000};
            8'h37: glyph = {8'b01111110, 8'b00000110, 8'b00001100, 8'b00011000,
                            8'b00110000, 8'b00110000, 8'b00110000, 8'b00000000};
            8'h38: glyph = {8'b00111100, 8'b01100110, 8'b01100110, 8'b00111100,
                            8'b01100110, 8'b01100110, 8'b00111100, 8'b00000000};
            8'h39: glyph = {8'b00111100, 8'b01100110, 8'b01100110, 8'b00111110,
                            8'b00000110, 8'b00000110, 8'b00111100, 8'b00000000};
            8'h41: glyph = {8'b00011000, 8'b00111100, 8'b01100110, 8'b01100110,
                            8'b01111110, 8'b01100110, 8'b01100110, 8'b00000000};
            8'h45: glyph = {8'b01111110, 8'b01100000, 8'b01100000, 8'b01111100,
                            8'b01100000, 8'b01100000, 8'b01111110, 8'b00000000};
            8'h47: glyph = {8'b00111100, 8'b01100110, 8'b01100000, 8'b01101110,
                            8'b01100110, 8'b01100110, 8'b00111100, 8'b00000000};
            8'h4C: glyph = {8'b01100000, 8'b01100000, 8'b01100000, 8'b01100000,
                            8'b01100000, 8'b01100000, 8'b01111110, 8'b00000000};
            8'h4D: glyph = {8'b01100011, 8'b01110111, 8'b01111111, 8'b01101011,
                            8'b01100011, 8'b01100011, 8'b01100011, 8'b00000000};
            8'h4F: glyph = {8'b00111100, 8'b01100110, 8'b01100110, 8'b01100110,
                            8'b01100110, 8'b01100110, 8'b00111100, 8'b00000000};
            8'h52: glyph = {8'b01111100, 8'b01100110, 8'b01100110, 8'b01111100,
                            8'b01101100, 8'b01100110, 8'b01100110, 8'b00000000};
            8'h53: glyph = {8'b00111110, 8'b01100000, 8'b01100000, 8'b00111100,
                            8'b00000110, 8'b00000110, 8'b01111100, 8'b00000000};
            8'h56: glyph = {8'b01100110, 8'b01100110, 8'b01100110, 8'b01100110,
                            8'b01100110, 8'b00111100, 8'b00011000, 8'b00000000};
            // space and anything unknown
            default: glyph = '0;
        endcase
    end

    assign bits = glyph[row];

endmodule

//--- design/pixel_capture.sv
`timescale 1ns/1ps

module pixel_capture (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                player_two,
    input  logic                game_over,
    input  logic                ball_send_trigger,
    input  logic                is_idle,
    input  overlay_pkg::coord_t x_pixel,
    input  overlay_pkg::coord_t y_pixel,
    input  overlay_pkg::coord_t ball_x,
    input  overlay_pkg::coord_t ball_y,
    input  logic [15:0]         camera_pixel,
    input  logic [15:0]         sprite_pixel,
    input  logic [7:0]          score,
    output logic [4:0]          x_offset,
    output logic [4:0]          y_offset,
    beam_if.source              beam
);
    import overlay_pkg::*;

    coord_t dx;
    coord_t dy;

    // sprite rom address, same cycle as the beam
    assign dx       = x_pixel - ball_x;
    assign dy       = y_pixel - ball_y;
    assign x_offset = dx[4:0];
    assign y_offset = dy[4:0];

    // beam and pixel payload
    always_ff @(posedge clk) begin
        beam.x          <= x_pixel;
        beam.y          <= y_pixel;
        beam.ball_x     <= ball_x;
        beam.ball_y     <= ball_y;
        beam.camera.raw <= camera_pixel;
        beam.sprite.raw <= sprite_pixel;
    end

    // game state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beam.score             <= 8'd0;
            beam.game_over         <= 1'b0;
            beam.player_two        <= 1'b0;
            beam.ball_send_trigger <= 1'b0;
            beam.is_idle           <= 1'b0;
        end else begin
            beam.score             <= score;
            beam.game_over         <= game_over;
            beam.player_two        <= player_two;
            beam.ball_send_trigger <= ball_send_trigger;
            beam.is_idle           <= is_idle;
        end
    end

endmodule

//--- design/score_text.sv
`timescale 1ns/1ps

module score_text (
    beam_if.consumer beam,
    output logic     score_box,
    output logic     score_lit
);
    import overlay_pkg::*;

    logic [7:0] tens_full;
    logic [7:0] ones_full;
    logic [3:0] tens;
    logic [3:0] ones;
    logic [7:0] code;
    logic [7:0] bits;
    coord_t     sx;
    coord_t     sy;
    coord_t     row_full;
    coord_t     col_full;

    // decimal split, tens kept to one nibble
    assign tens_full = beam.score / 8'd10;
    assign ones_full = beam.score % 8'd10;
    assign tens      = tens_full[3:0];
    assign ones      = ones_full[3:0];

    assign sx = beam.x - coord_t'(SCORE_X);
    assign sy = beam.y - coord_t'(SCORE_Y);

    assign score_box = (beam.x >= coord_t'(SCORE_X)) &&
                       (sx < coord_t'(2 * FONT_W * TEXT_SCALE)) &&
                       (beam.y >= coord_t'(SCORE_Y)) &&
                       (sy < coord_t'(FONT_H * TEXT_SCALE));

    // col_full bit 3 picks the ones digit
    assign row_full = sy / coord_t'(TEXT_SCALE);
    assign col_full = sx / coord_t'(TEXT_SCALE);

    assign code = col_full[3] ? ASCII_ZERO + {4'd0, ones} : ASCII_ZERO + {4'd0, tens};

    glyph_rom u_glyph (
        .code (code),
        .row  (row_full[2:0]),
        .bits (bits)
    );

    assign score_lit = score_box && bits[3'd7 - col_full[2:0]];

endmodule

//--- design/banner_text.sv
`timescale 1ns/1ps

module banner_text (
    beam_if.consumer beam,
    output logic     banner_lit
);
    import overlay_pkg::*;

    coord_t     org_x;
    coord_t     width;
    coord_t     bx;
    coord_t     by;
    coord_t     char_idx;
    coord_t     row_idx;
    coord_t     col_idx;
    logic       in_box;
    logic [7:0] code;
    logic [7:0] bits;

    // two-player shows LOSE, one-player GAME OVER
    always_comb begin
        if (beam.player_two) begin
            org_x = coord_t'(LOSE_X);
            width = coord_t'(LOSE_LEN * FONT_W * TEXT_SCALE);
        end else begin
            org_x = coord_t'(GAMEOVER_X);
            width = coord_t'(GAMEOVER_LEN * FONT_W * TEXT_SCALE);
        end
    end

    assign bx = beam.x - org_x;
    assign by = beam.y - coord_t'(BANNER_Y);

    assign in_box = (beam.x >= org_x) && (bx < width) &&
                    (beam.y >= coord_t'(BANNER_Y)) &&
                    (by < coord_t'(FONT_H * TEXT_SCALE));

    // each character cell is 16 pixels wide
    assign char_idx = bx / coord_t'(FONT_W * TEXT_SCALE);
    assign row_idx  = by / coord_t'(TEXT_SCALE);
    assign col_idx  = (bx % coord_t'(FONT_W * TEXT_SCALE)) / coord_t'(TEXT_SCALE);

    always_comb begin
        if (beam.player_two) begin
            code = LOSE_STR[char_idx[1:0]];
        end else if (char_idx < coord_t'(GAMEOVER_LEN)) begin
            code = GAMEOVER_STR[char_idx[3:0]];
        end else begin
            code = 8'h20;
        end
    end

    glyph_rom u_glyph (
        .code (code),
        .row  (row_idx[2:0]),
        .bits (bits)
    );

    assign banner_lit = beam.game_over && in_box && bits[3'd7 - col_idx[2:0]];

endmodule

//--- design/pixel_mixer.sv
`timescale 1ns/1ps

module pixel_mixer (
    input  logic       clk,
    input  logic       rst_n,
    beam_if.consumer   beam,
    input  logic       score_box,
    input  logic       score_lit,
    input  logic       banner_lit,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue,
    output logic       is_hit_area
);
    import overlay_pkg::*;

    logic [10:0] ball_x_end;
    logic [10:0] ball_y_end;
    logic        in_ball;
    logic        sprite_hidden;
    pixel_u      disp;

    // eleven bits so the window edge never wraps
    assign ball_x_end = {1'b0, beam.ball_x} + 11'(BALL_SIZE);
    assign ball_y_end = {1'b0, beam.ball_y} + 11'(BALL_SIZE);

    assign in_ball = (beam.x >= beam.ball_x) && ({1'b0, beam.x} < ball_x_end) &&
                     (beam.y >= beam.ball_y) && ({1'b0, beam.y} < ball_y_end);

    // ball is drawn only while in play
    assign sprite_hidden = beam.game_over || beam.ball_send_trigger || beam.is_idle;

    always_comb begin
        if (banner_lit) begin
            disp.raw = BANNER_RED;
        end else if (in_ball && beam.sprite.raw != 16'h0000) begin
            disp = sprite_hidden ? beam.camera : beam.sprite;
        end else if (score_box) begin
            disp.raw = score_lit ? TEXT_WHITE : BLACK;
        end else begin
            disp = beam.camera;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            red         <= 4'd0;
            green       <= 4'd0;
            blue        <= 4'd0;
            is_hit_area <= 1'b0;
        end else begin
            red         <= disp.field.red[4:1];
            green       <= disp.field.green[5:2];
            blue        <= disp.field.blue[4:1];
            is_hit_area <= in_ball;
        end
    end

endmodule

//--- design/overlay_top.sv
`timescale 1ns/1ps

module overlay_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                player_two,
    input  logic                game_over,
    input  logic                ball_send_trigger,
    input  logic                is_idle,
    input  overlay_pkg::coord_t x_pixel,
    input  overlay_pkg::coord_t y_pixel,
    input  overlay_pkg::coord_t ball_x,
    input  overlay_pkg::coord_t ball_y,
    input  logic [15:0]         camera_pixel,
    input  logic [15:0]         sprite_pixel,
    input  logic [7:0]          score,
    output logic [4:0]          x_offset,
    output logic [4:0]          y_offset,
    output logic [3:0]          red,
    output logic [3:0]          green,
    output logic [3:0]          blue,
    output logic                is_hit_area
);

    logic score_box;
    logic score_lit;
    logic banner_lit;

    beam_if beam ();

    // stage 1 registers the beam
    pixel_capture u_capture (
        .clk               (clk),
        .rst_n             (rst_n),
        .player_two        (player_two),
        .game_over         (game_over),
        .ball_send_trigger (ball_send_trigger),
        .is_idle           (is_idle),
        .x_pixel           (x_pixel),
        .y_pixel           (y_pixel),
        .ball_x            (ball_x),
        .ball_y            (ball_y),
        .camera_pixel      (camera_pixel),
        .sprite_pixel      (sprite_pixel),
        .score             (score),
        .x_offset          (x_offset),
        .y_offset          (y_offset),
        .beam              (beam)
    );

    score_text u_score (
        .beam      (beam),
        .score_box (score_box),
        .score_lit (score_lit)
    );

    banner_text u_banner (
        .beam       (beam),
        .banner_lit (banner_lit)
    );

    // stage 2 registers the colour
    pixel_mixer u_mixer (
        .clk         (clk),
        .rst_n       (rst_n),
        .beam        (beam),
        .score_box   (score_box),
        .score_lit   (score_lit),
        .banner_lit  (banner_lit),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .is_hit_area (is_hit_area)
    );

endmodule

//--- tb/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held over the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- tb/overlay_tb.sv
`timescale 1ns/1ps

module overlay_tb;

    localparam int MAX_ROWS  = 64;
    localparam int SCORE_VAL = 37;

    typedef struct packed {
        logic [9:0]  x;
        logic [9:0]  y;
        logic [9:0]  ball_x;
        logic [9:0]  ball_y;
        logic [15:0] camera;
        logic [15:0] sprite;
        logic        game_over;
        logic        player_two;
        logic        trigger;
        logic        idle;
        logic [4:0]  exp_xoff;
        logic [4:0]  exp_yoff;
        logic [3:0]  exp_red;
        logic [3:0]  exp_green;
        logic [3:0]  exp_blue;
        logic        exp_hit;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        player_two;
    logic        game_over;
    logic        ball_send_trigger;
    logic        is_idle;
    logic [9:0]  x_pixel;
    logic [9:0]  y_pixel;
    logic [9:0]  ball_x;
    logic [9:0]  ball_y;
    logic [15:0] camera_pixel;
    logic [15:0] sprite_pixel;
    logic [7:0]  score;
    logic [4:0]  x_offset;
    logic [4:0]  y_offset;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;
    logic        is_hit_area;

    row_t   rows [0:MAX_ROWS-1];
    int     n_rows = 0;
    int     checks = 0;
    int     errors = 0;
    integer seed;
    logic   table_built = 1'b0;

    clk_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    overlay_top dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .player_two        (player_two),
        .game_over         (game_over),
        .ball_send_trigger (ball_send_trigger),
        .is_idle           (is_idle),
        .x_pixel           (x_pixel),
        .y_pixel           (y_pixel),
        .ball_x            (ball_x),
        .ball_y            (ball_y),
        .camera_pixel      (camera_pixel),
        .sprite_pixel      (sprite_pixel),
        .score             (score),
        .x_offset          (x_offset),
        .y_offset          (y_offset),
        .red               (red),
        .green             (green),
        .blue              (blue),
        .is_hit_area       (is_hit_area)
    );

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return r % n;
    endfunction

    function automatic logic [15:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    // glyphs of the score 37 and of both banners
    function automatic logic [7:0] font_row(input logic [7:0] code, input int row);
        logic [63:0] g;
        case (code)
            8'h33:   g = 64'h3C66061C06663C00;
            8'h37:   g = 64'h7E060C1830303000;
            8'h41:   g = 64'h183C66667E666600;
            8'h45:   g = 64'h7E60607C60607E00;
            8'h47:   g = 64'h3C66606E66663C00;
            8'h4C:   g = 64'h6060606060607E00;
            8'h4D:   g = 64'h63777F6B63636300;
            8'h4F:   g = 64'h3C66666666663C00;
            8'h52:   g = 64'h7C66667C6C666600;
            8'h53:   g = 64'h3E60603C06067C00;
            8'h56:   g = 64'h66666666663C1800;
            default: g = 64'h0;
        endcase
        return g[8 * (7 - row) +: 8];
    endfunction

    function automatic logic font_lit(input logic [7:0] code, input int row, input int col);
        logic [7:0] bits;
        bits = font_row(code, row);
        return bits[7 - col];
    endfunction

    function automatic logic banner_on(input int x, input int y, input logic p2);
        string text;
        int    org;
        int    bx;
        int    by;
        if (p2) begin
            text = "LOSE";
            org  = 280;
        end else begin
            text = "GAME OVER";
            org  = 250;
        end
        bx = x - org;
        by = y - 200;
        if (bx < 0 || bx >= text.len() * 16 || by < 0 || by >= 16)
            return 1'b0;
        return font_lit(text[bx / 16], by / 2, (bx % 16) / 2);
    endfunction

    // {inside box, lit}
    function automatic logic [1:0] score_on(input int x, input int y, input int value);
        int sx;
        int sy;
        int col;
        int digit;
        sx = x - 500;
        sy = y - 40;
        if (sx < 0 || sx >= 32 || sy < 0 || sy >= 16)
            return 2'b00;
        col   = sx / 2;
        digit = (col < 8) ? value / 10 : value % 10;
        return {1'b1, font_lit(8'h30 + digit, sy / 2, col % 8)};
    endfunction

    task automatic add_row(input int x, input int y, input int bx, input int by,
                           input logic [15:0] cam, input logic [15:0] spr,
                           input logic go, input logic p2, input logic trig,
                           input logic idle);
        row_t        r;
        logic [15:0] c;
        logic [1:0]  sc;
        logic        in_ball;
        logic [9:0]  dx;
        logic [9:0]  dy;
        in_ball = (x >= bx) && (x < bx + 20) && (y >= by) && (y < by + 20);
        sc      = score_on(x, y, SCORE_VAL);
        if (go && banner_on(x, y, p2))
            c = 16'hF001;
        else if (in_ball && spr != 16'h0000)
            c = (go || trig || idle) ? cam : spr;
        else if (sc[1])
            c = sc[0] ? 16'hFFFF : 16'h0000;
        else
            c = cam;
        dx           = x - bx;
        dy           = y - by;
        r.x          = x;
        r.y          = y;
        r.ball_x     = bx;
        r.ball_y     = by;
        r.camera     = cam;
        r.sprite     = spr;
        r.game_over  = go;
        r.player_two = p2;
        r.trigger    = trig;
        r.idle       = idle;
        r.exp_xoff   = dx[4:0];
        r.exp_yoff   = dy[4:0];
        // upper nibble of each rgb565 field
        r.exp_red    = c[15:12];
        r.exp_green  = c[10:7];
        r.exp_blue   = c[4:1];
        r.exp_hit    = in_ball;
        rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic drive_row(input row_t r);
        x_pixel           <= r.x;
        y_pixel           <= r.y;
        ball_x            <= r.ball_x;
        ball_y            <= r.ball_y;
        camera_pixel      <= r.camera;
        sprite_pixel      <= r.sprite;
        game_over         <= r.game_over;
        player_two        <= r.player_two;
        ball_send_trigger <= r.trigger;
        is_idle           <= r.idle;
    endtask

    task automatic check_value(input string name, input int row,
                               input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s row %0d: got 0x%0h, expected 0x%0h", name, row, got, exp);
        end
    endtask

    task automatic check_outputs(input int row, input logic [3:0] er, input logic [3:0] eg,
                                 input logic [3:0] eb, input logic eh);
        check_value("red", row, red, er);
        check_value("green", row, green, eg);
        check_value("blue", row, blue, eb);
        check_value("is_hit_area", row, is_hit_area, eh);
    endtask

    task automatic build_table();
        int          k;
        int          rx;
        int          ry;
        logic [15:0] spr;
        // outside every overlay
        add_row(100, 100, 600, 440, rand_word(), 16'h0000, 0, 0, 0, 0);
        add_row(320, 240, 600, 440, rand_word(), 16'h7BEF, 0, 0, 0, 0);
        add_row(639, 479, 600, 440, rand_word(), 16'h0000, 0, 0, 0, 0);
        // ball window edges at 100,300
        add_row(100, 300, 100, 300, rand_word(), 16'hF81F, 0, 0, 0, 0);
        add_row(119, 319, 100, 300, rand_word(), 16'hF81F, 0, 0, 0, 0);
        add_row(120, 300, 100, 300, rand_word(), 16'hF81F, 0, 0, 0, 0);
        add_row(110, 320, 100, 300, rand_word(), 16'hF81F, 0, 0, 0, 0);
        add_row(99, 305, 100, 300, rand_word(), 16'hF81F, 0, 0, 0, 0);
        add_row(105, 305, 100, 300, rand_word(), 16'h0000, 0, 0, 0, 0);
        add_row(105, 305, 100, 300, rand_word(), 16'h07E0, 0, 0, 1, 0);
        add_row(105, 305, 100, 300, rand_word(), 16'h07E0, 0, 0, 0, 1);
        add_row(105, 305, 100, 300, rand_word(), 16'h07E0, 1, 0, 0, 0);
        // score box tens digit then ones digit
        add_row(504, 40, 600, 440, rand_word(), 16'h0000, 0, 0, 0, 0);
        add_row(500, 40, 600, 440, rand_word(), 16'h0000, 0, 0, 0, 0);
        add_row(518, 40, 600, 440, rand_word(), 16'h0000, 0, 0, 0, 0);
        add_row(530, 40, 600, 440, rand_word(), 16'h0000, 0, 0, 0, 0);
        add_row(506, 46, 600, 440, rand_word(), 16'h0000, 0, 0, 0, 0);
        add_row(500, 54, 600, 440, rand_word(), 16'h0000, 0, 0, 0, 0);
        add_row(532, 40, 600, 440, rand_word(), 16'h0000, 0, 0, 0, 0);
        add_row(499, 40, 600, 440, rand_word(), 16'h0000, 0, 0, 0, 0);
        // banner over the ball and then without game_over
        add_row(254, 200, 250, 200, rand_word(), 16'hF81F, 1, 0, 0, 0);
        add_row(254, 200, 250, 200, rand_word(), 16'hF81F, 0, 0, 0, 0);
        add_row(284, 200, 600, 440, rand_word(), 16'h0000, 1, 0, 0, 0);
        add_row(322, 200, 600, 440, rand_word(), 16'h0000, 1, 0, 0, 0);
        add_row(380, 206, 600, 440, rand_word(), 16'h0000, 1, 0, 0, 0);
        add_row(282, 200, 600, 440, rand_word(), 16'h0000, 1, 1, 0, 0);
        add_row(332, 200, 600, 440, rand_word(), 16'h0000, 1, 1, 0, 0);
        add_row(344, 200, 600, 440, rand_word(), 16'h0000, 1, 1, 0, 0);
        add_row(254, 200, 600, 440, rand_word(), 16'h0000, 1, 1, 0, 0);
        // scattered around the banner and the score box
        for (k = 0; k < 16; k++) begin
            if (k % 2 == 0) begin
                rx = 240 + rand_below(160);
                ry = 196 + rand_below(24);
            end else begin
                rx = 494 + rand_below(44);
                ry = 34 + rand_below(28);
            end
            spr = (rand_below(4) == 0) ? 16'h0000 : rand_word();
            add_row(rx, ry, rx - rand_below(24), ry - rand_below(24), rand_word(), spr,
                    rand_below(2), rand_below(2), rand_below(8) == 0, rand_below(8) == 0);
        end
    endtask

    initial begin
        int i;
        player_two        = 1'b0;
        game_over         = 1'b0;
        ball_send_trigger = 1'b0;
        is_idle           = 1'b0;
        x_pixel           = 10'd0;
        y_pixel           = 10'd0;
        ball_x            = 10'd600;
        ball_y            = 10'd400;
        camera_pixel      = 16'h0000;
        sprite_pixel      = 16'h0000;
        score             = 8'(SCORE_VAL);
        seed              = 32'h8f5819bf;
        build_table();
        table_built = 1'b1;

        // first reset edge, then look half a cycle later
        @(posedge clk);
        @(negedge clk);
        check_outputs(-1, 4'h0, 4'h0, 4'h0, 1'b0);
        @(posedge rst_n);

        // row i checked two edges after it is applied
        for (i = 0; i < n_rows + 2; i++) begin
            @(posedge clk);
            if (i < n_rows)
                drive_row(rows[i]);
            @(negedge clk);
            if (i < n_rows) begin
                check_value("x_offset", i, x_offset, rows[i].exp_xoff);
                check_value("y_offset", i, y_offset, rows[i].exp_yoff);
            end
            if (i >= 2)
                check_outputs(i - 2, rows[i-2].exp_red, rows[i-2].exp_green,
                              rows[i-2].exp_blue, rows[i-2].exp_hit);
            else
                check_outputs(-1, 4'h0, 4'h0, 4'h0, 1'b0);
        end

        $display("%0d rows, %0d checks, %0d errors", n_rows, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial begin
        wait (table_built);
        #((n_rows + 20) * 20);
        $display("timeout: pipeline did not finish within %0d cycles", n_rows + 20);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- compile.f
design/overlay_pkg.sv
design/beam_if.sv
design/glyph_rom.sv
design/pixel_capture.sv
design/score_text.sv
design/banner_text.sv
design/pixel_mixer.sv
design/overlay_top.sv
tb/clk_gen.sv
tb/overlay_tb.sv

//--- Bender.yml
package:
  name: pixel_overlay

sources:
  - design/overlay_pkg.sv
  - design/beam_if.sv
  - design/glyph_rom.sv
  - design/pixel_capture.sv
  - design/score_text.sv
  - design/banner_text.sv
  - design/pixel_mixer.sv
  - design/overlay_top.sv
  - target: test
    files:
      - tb/clk_gen.sv
      - tb/overlay_tb.sv
